// ==== verilog/decOp_params.svh ====
// fixed encodings for the decode stage; ids and codes must match the downstream pipeline
`ifndef DECOP_PARAMS_SVH
`define DECOP_PARAMS_SVH

`define DECOP_ISTR_W 32
`define DECOP_REG_W 6
`define DECOP_IMM_W 33

// special register ids
`define DECOP_GR_PC 6'h20
`define DECOP_GR_GBR 6'h21
`define DECOP_GR_IMM 6'h2F
`define DECOP_GR_DLR 6'h30
`define DECOP_GR_TBR 6'h31
`define DECOP_GR_ZZR 6'h3F

// command codes
`define DECOP_UCMD_INVOP 6'h00
`define DECOP_UCMD_MOV_RM 6'h01
`define DECOP_UCMD_MOV_MR 6'h02
`define DECOP_UCMD_LEA_MR 6'h03
`define DECOP_UCMD_ALU3 6'h04
`define DECOP_UCMD_ALUCMP 6'h05
`define DECOP_UCMD_MOV_IR 6'h06
`define DECOP_UCMD_BRA 6'h07
`define DECOP_UCMD_BSR 6'h08

// ALU sub-ops, quad compares sit one above the 32-bit form
`define DECOP_UCIX_ALU_ADD 6'h00
`define DECOP_UCIX_ALU_SUB 6'h01
`define DECOP_UCIX_ALU_AND 6'h05
`define DECOP_UCIX_ALU_OR 6'h06
`define DECOP_UCIX_ALU_XOR 6'h07
`define DECOP_UCIX_ALU_TST 6'h10
`define DECOP_UCIX_ALU_TSTQ 6'h11
`define DECOP_UCIX_ALU_CMPHS 6'h12
`define DECOP_UCIX_ALU_CMPQHS 6'h13
`define DECOP_UCIX_ALU_CMPHI 6'h14
`define DECOP_UCIX_ALU_CMPQHI 6'h15
`define DECOP_UCIX_ALU_CMPGE 6'h16
`define DECOP_UCIX_ALU_CMPQGE 6'h17
`define DECOP_UCIX_ALU_CMPEQ 6'h18
`define DECOP_UCIX_ALU_CMPQEQ 6'h19
`define DECOP_UCIX_ALU_CMPGT 6'h1A
`define DECOP_UCIX_ALU_CMPQGT 6'h1B

// load-immediate sub-ops
`define DECOP_UCIX_LDI_LDIX 6'h00
`define DECOP_UCIX_LDI_LDISH16 6'h01

`endif

// ==== verilog/decOpPkg.sv ====
// types shared by the decode stage; enum values come from decOp_params.svh
`include "decOp_params.svh"

package decOpPkg;

	typedef logic [`DECOP_ISTR_W-1:0] istrWord_t;
	typedef logic [`DECOP_REG_W-1:0] regId_t;
	typedef logic [`DECOP_IMM_W-1:0] imm_t;
	typedef logic [7:0] uCmd_t;
	typedef logic [7:0] uIxt_t;

	typedef enum logic [5:0] {
		NM_INVOP = `DECOP_UCMD_INVOP,
		NM_MOV_RM = `DECOP_UCMD_MOV_RM,
		NM_MOV_MR = `DECOP_UCMD_MOV_MR,
		NM_LEA_MR = `DECOP_UCMD_LEA_MR,
		NM_ALU3 = `DECOP_UCMD_ALU3,
		NM_ALUCMP = `DECOP_UCMD_ALUCMP,
		NM_MOV_IR = `DECOP_UCMD_MOV_IR,
		NM_BRA = `DECOP_UCMD_BRA,
		NM_BSR = `DECOP_UCMD_BSR
	} nmid_e;

	typedef enum logic [4:0] {
		FM_Z, FM_INV, FM_REGREG, FM_REGIMMREG,
		FM_LDREGDISPREG, FM_REGSTREGDISP, FM_LDDRREGREG, FM_REGSTDRREG,
		FM_IMM8REG, FM_PCDISP8, FM_IMM12Z, FM_IMM12N
	} fmid_e;

	typedef enum logic [3:0] {
		ITY_SB = 4'h0, ITY_SW = 4'h1, ITY_SQ = 4'h2,
		ITY_UB = 4'h4, ITY_UW = 4'h5, ITY_UQ = 4'h6,
		ITY_NB = 4'h8, ITY_NW = 4'h9, ITY_NQ = 4'hA
	} ity_e;

	// low two bits give the size, top bit marks unsigned
	typedef enum logic [2:0] {
		BTY_SB = 3'h0, BTY_SW = 3'h1, BTY_SL = 3'h2, BTY_SQ = 3'h3,
		BTY_UB = 3'h4, BTY_UW = 3'h5, BTY_UL = 3'h6
	} bty_e;

	typedef enum logic [1:0] {
		CC_AL = 2'b00, CC_CT = 2'b10, CC_CF = 2'b11
	} ccty_e;

	typedef struct packed {
		regId_t regN;
		regId_t regM;
		regId_t regO;
		regId_t regO2;
		logic exQ;
		logic rmIsRz;
		logic rmIsR1;
		logic roIsR1;
	} istrFields_t;

	typedef struct packed {
		imm_t imm17u;
		imm_t imm17n;
		imm_t imm10s;
		imm_t imm10u;
		imm_t imm10n;
		imm_t imm16s;
		imm_t imm16u;
		imm_t imm16n;
		imm_t disp20s;
		imm_t imm12z;
		imm_t imm12n;
		imm_t imm5u;
	} immSet_t;

	typedef struct packed {
		nmid_e nmid;
		fmid_e fmid;
		bty_e bty;
		ity_e ity;
		ccty_e ccty;
		logic [5:0] uCmdIx;
	} opClass_t;

	typedef struct packed {
		regId_t regN;
		regId_t regM;
		regId_t regO;
		imm_t imm;
		uCmd_t uCmd;
		uIxt_t uIxt;
	} decodedOp_t;

endpackage

// ==== verilog/opFieldSplit.sv ====
// combinational; register fields are only meaningful for F-block words
`timescale 1ns/1ps

module opFieldSplit (
	input decOpPkg::istrWord_t istrWord,
	output decOpPkg::istrFields_t fields
);
	import decOpPkg::*;

	logic rnIsRs;
	logic rmIsRs;
	logic roIsRs;
	regId_t regM;
	regId_t regO;

	// fields 0, 1 and 15 land in the special bank
	assign rnIsRs = (istrWord[7:5] == 3'b000) || (istrWord[7:4] == 4'hF);
	assign rmIsRs = (istrWord[3:1] == 3'b000) || (istrWord[3:0] == 4'hF);
	assign roIsRs = (istrWord[23:21] == 3'b000) || (istrWord[23:20] == 4'hF);

	assign regM = {rmIsRs, istrWord[25], istrWord[3:0]};
	assign regO = {roIsRs, istrWord[24], istrWord[23:20]};

	always_comb begin
		fields.regN = {rnIsRs, istrWord[26], istrWord[7:4]};
		fields.regM = regM;
		fields.regO = regO;
		// second O id for the short immediate forms
		fields.regO2 = {rmIsRs, istrWord[4], istrWord[3:0]};
		fields.exQ = istrWord[27];
		// R0 or R1 with the extension bit clear
		fields.rmIsRz = (regM[4:1] == 4'b0000);
		fields.rmIsR1 = (regM[4:0] == 5'b00001);
		fields.roIsR1 = (regO[4:0] == 5'b00001);
	end

endmodule

// ==== verilog/immExtend.sv ====
// combinational; every candidate is built, the form picks one downstream
`timescale 1ns/1ps

module immExtend (
	input decOpPkg::istrWord_t istrWord,
	output decOpPkg::immSet_t imms
);
	import decOpPkg::*;

	logic [8:0] imm17;
	logic [9:0] imm10;
	logic [15:0] imm16;
	logic [19:0] disp20;
	logic [23:0] imm12;

	assign imm17 = istrWord[24:16];
	assign imm10 = istrWord[25:16];
	assign imm16 = istrWord[31:16];
	assign disp20 = {istrWord[7:0], istrWord[27:16]};
	assign imm12 = {istrWord[7:0], istrWord[31:16]};

	always_comb begin
		imms.imm17u = {{24{1'b0}}, imm17};
		imms.imm17n = {{24{1'b1}}, imm17};

		imms.imm10s = {{23{imm10[9]}}, imm10};
		imms.imm10u = {{23{1'b0}}, imm10};
		imms.imm10n = {{23{1'b1}}, imm10};

		imms.imm16s = {{17{imm16[15]}}, imm16};
		imms.imm16u = {{17{1'b0}}, imm16};
		imms.imm16n = {{17{1'b1}}, imm16};

		// branch displacement, sign from the high byte
		imms.disp20s = {{13{disp20[19]}}, disp20};

		imms.imm12z = {{9{1'b0}}, imm12};
		imms.imm12n = {{9{1'b1}}, imm12};

		imms.imm5u = {{28{1'b0}}, istrWord[4:0]};
	end

endmodule

// ==== verilog/opClassDecode.sv ====
// combinational; only the kept F0/F1/F2/F8/FA/FB groups decode, all else is INV or Z
`timescale 1ns/1ps
`include "decOp_params.svh"

module opClassDecode (
	input decOpPkg::istrWord_t istrWord,
	output decOpPkg::opClass_t opClass
);
	import decOpPkg::*;

	logic exQ;
	logic [6:0] aluOp;

	// {valid, sub-op} for the five kept ALU ops
	function automatic logic [6:0] aluSel(input logic [3:0] digit);
		logic [6:0] sel;
		case (digit)
			4'h0: sel = {1'b1, `DECOP_UCIX_ALU_ADD};
			4'h1: sel = {1'b1, `DECOP_UCIX_ALU_SUB};
			4'h5: sel = {1'b1, `DECOP_UCIX_ALU_AND};
			4'h6: sel = {1'b1, `DECOP_UCIX_ALU_OR};
			4'h7: sel = {1'b1, `DECOP_UCIX_ALU_XOR};
			default: sel = 7'h00;
		endcase
		return sel;
	endfunction

	// load width, exQ picks the unsigned variant
	function automatic bty_e ldWidth(input logic [1:0] size, input logic uns);
		bty_e w;
		case (size)
			2'd0: w = uns ? BTY_UB : BTY_SB;
			2'd1: w = uns ? BTY_UW : BTY_SW;
			2'd2: w = uns ? BTY_UL : BTY_SL;
			default: w = uns ? BTY_SL : BTY_SQ;
		endcase
		return w;
	endfunction

	assign exQ = istrWord[27];

	always_comb begin
		aluOp = 7'h00;
		opClass.nmid = NM_INVOP;
		opClass.fmid = FM_INV;
		opClass.bty = BTY_SB;
		opClass.ity = ITY_SB;
		opClass.ccty = CC_AL;
		opClass.uCmdIx = 6'h00;

		casez (istrWord[11:8])
			4'b0z00: casez (istrWord[31:16])
				// indexed store, or LEA when exQ
				16'b0000_zzzz_zzzz_01zz: begin
					opClass.nmid = exQ ? NM_LEA_MR : NM_MOV_RM;
					opClass.fmid = exQ ? FM_LDDRREGREG : FM_REGSTDRREG;
					opClass.bty = bty_e'({1'b0, istrWord[17:16]});
					opClass.ity = ITY_UB;
				end
				16'b0000_zzzz_zzzz_11zz: begin
					opClass.nmid = NM_MOV_MR;
					opClass.fmid = FM_LDDRREGREG;
					opClass.bty = ldWidth(istrWord[17:16], exQ);
					opClass.ity = ITY_UB;
				end
				16'h1zz8, 16'h1zz9: begin
					aluOp = aluSel(istrWord[23:20]);
					if (aluOp[6]) begin
						opClass.nmid = NM_ALU3;
						opClass.fmid = FM_REGREG;
						opClass.ity = istrWord[16] ? ITY_NB : ITY_UB;
						opClass.uCmdIx = aluOp[5:0];
					end
				end
				16'h1zzz: begin
					aluOp = aluSel(istrWord[19:16]);
					if (aluOp[6]) begin
						opClass.nmid = NM_ALU3;
						opClass.fmid = FM_REGREG;
						opClass.uCmdIx = aluOp[5:0];
					end
				end
				// Cddd BRA, Dddd BSR, Eddd BT, Fddd BF
				16'b11zz_zzzz_zzzz_zzzz: begin
					opClass.nmid = (istrWord[29:28] == 2'b01) ? NM_BSR : NM_BRA;
					opClass.fmid = FM_PCDISP8;
					opClass.bty = BTY_SW;
					opClass.ity = ITY_SW;
					opClass.ccty = istrWord[29] ? ccty_e'({1'b1, istrWord[28]}) : CC_AL;
				end
				default: begin
				end
			endcase

			4'b0z01: casez (istrWord[31:28])
				4'b00zz: begin
					opClass.nmid = exQ ? NM_LEA_MR : NM_MOV_RM;
					opClass.fmid = exQ ? FM_LDREGDISPREG : FM_REGSTREGDISP;
					opClass.bty = bty_e'({1'b0, istrWord[29:28]});
					opClass.ity = ITY_SW;
				end
				4'b10zz: begin
					opClass.nmid = NM_MOV_MR;
					opClass.fmid = FM_LDREGDISPREG;
					opClass.bty = ldWidth(istrWord[29:28], exQ);
					opClass.ity = ITY_SW;
				end
				default: begin
				end
			endcase

			4'b0z10: case (istrWord[31:28])
				4'h1: begin
					opClass.nmid = NM_ALU3;
					opClass.fmid = FM_REGIMMREG;
					opClass.ity = ITY_NW;
					opClass.uCmdIx = `DECOP_UCIX_ALU_ADD;
				end
				// compare or move against imm10, bit 0 picks ones extension
				4'hC: begin
					opClass.ity = istrWord[0] ? ITY_NQ : ITY_UQ;
					opClass.fmid = FM_IMM8REG;
					opClass.nmid = NM_ALUCMP;
					case (istrWord[3:1])
						3'b000: opClass.nmid = NM_MOV_IR;
						3'b010: opClass.uCmdIx = exQ ? `DECOP_UCIX_ALU_TSTQ : `DECOP_UCIX_ALU_TST;
						3'b011: opClass.uCmdIx = exQ ? `DECOP_UCIX_ALU_CMPQHS : `DECOP_UCIX_ALU_CMPHS;
						3'b100: opClass.uCmdIx = exQ ? `DECOP_UCIX_ALU_CMPQHI : `DECOP_UCIX_ALU_CMPHI;
						3'b101: opClass.uCmdIx = exQ ? `DECOP_UCIX_ALU_CMPQGE : `DECOP_UCIX_ALU_CMPGE;
						3'b110: opClass.uCmdIx = exQ ? `DECOP_UCIX_ALU_CMPQEQ : `DECOP_UCIX_ALU_CMPEQ;
						3'b111: opClass.uCmdIx = exQ ? `DECOP_UCIX_ALU_CMPQGT : `DECOP_UCIX_ALU_CMPGT;
						default: begin
							opClass.nmid = NM_INVOP;
							opClass.fmid = FM_INV;
						end
					endcase
				end
				default: begin
					aluOp = aluSel(istrWord[31:28]);
					if (aluOp[6]) begin
						opClass.nmid = NM_ALU3;
						opClass.fmid = FM_REGIMMREG;
						opClass.ity = ITY_UW;
						opClass.uCmdIx = aluOp[5:0];
					end
				end
			endcase

			4'b100z: begin
				opClass.fmid = FM_IMM8REG;
				opClass.nmid = NM_MOV_IR;
				case (istrWord[7:5])
					3'b000: opClass.ity = ITY_UW;
					3'b001: opClass.ity = ITY_NW;
					3'b010: begin
						opClass.nmid = NM_ALU3;
						opClass.ity = ITY_SW;
					end
					3'b011: begin
						opClass.ity = ITY_UW;
						opClass.uCmdIx = `DECOP_UCIX_LDI_LDISH16;
					end
					default: begin
						opClass.nmid = NM_INVOP;
						opClass.fmid = FM_INV;
					end
				endcase
			end

			4'hA, 4'hB: begin
				opClass.nmid = NM_MOV_IR;
				opClass.fmid = istrWord[8] ? FM_IMM12N : FM_IMM12Z;
				opClass.uCmdIx = `DECOP_UCIX_LDI_LDIX;
			end

			default: begin
			end
		endcase

		// not an F-block word
		if (istrWord[15:13] != 3'b111) begin
			opClass.fmid = FM_Z;
			opClass.ccty = CC_AL;
		end
	end

	// operandForm only knows these three operand orders for REGREG
	always_comb begin
		assert final (opClass.fmid != FM_REGREG ||
			opClass.ity inside {ITY_SB, ITY_UB, ITY_NB})
		else $error("REGREG decoded with ity %0d", opClass.ity);
	end

endmodule

// ==== verilog/operandForm.sv ====
// output registered one cycle after the word; no stall or valid
`timescale 1ns/1ps
`include "decOp_params.svh"

module operandForm (
	input logic clock,
	input logic reset,
	input decOpPkg::istrWord_t istrWord,
	input decOpPkg::istrFields_t fields,
	input decOpPkg::immSet_t imms,
	input decOpPkg::opClass_t opClass,
	output decOpPkg::decodedOp_t decodedOp
);
	import decOpPkg::*;

	decodedOp_t nextOp;
	uIxt_t memIxt;
	uIxt_t memIxtBase;
	uIxt_t aluIxt;

	// base-register variant of the width field drops the low size bits
	assign memIxt = {opClass.ccty, opClass.bty[1:0], 1'b1, opClass.bty};
	assign memIxtBase = {opClass.ccty, opClass.bty[1:0], 1'b1, opClass.bty[2], 2'b00};
	assign aluIxt = {opClass.ccty, opClass.uCmdIx};

	always_comb begin
		nextOp.regN = `DECOP_GR_ZZR;
		nextOp.regM = `DECOP_GR_ZZR;
		nextOp.regO = `DECOP_GR_ZZR;
		nextOp.imm = '0;
		nextOp.uCmd = {opClass.ccty, opClass.nmid};
		nextOp.uIxt = '0;

		case (opClass.fmid)
			FM_REGREG: begin
				nextOp.regN = fields.regN;
				nextOp.imm = imms.imm5u;
				nextOp.uIxt = aluIxt;
				case (opClass.ity)
					ITY_UB: begin
						nextOp.regM = fields.regM;
						nextOp.regO = fields.regN;
					end
					ITY_NB: begin
						nextOp.regM = fields.regN;
						nextOp.regO = fields.regM;
					end
					default: begin
						nextOp.regM = fields.regM;
						nextOp.regO = fields.regO;
					end
				endcase
			end
			FM_REGIMMREG: begin
				nextOp.regN = fields.regN;
				nextOp.regM = fields.regM;
				nextOp.regO = `DECOP_GR_IMM;
				nextOp.imm = (opClass.ity == ITY_NW) ? imms.imm17n : imms.imm17u;
				nextOp.uIxt = aluIxt;
			end
			FM_LDREGDISPREG, FM_REGSTREGDISP: begin
				nextOp.regN = fields.regN;
				nextOp.regM = fields.regM;
				nextOp.regO = `DECOP_GR_IMM;
				nextOp.imm = imms.imm17u;
				nextOp.uIxt = memIxt;
				if (fields.rmIsRz) begin
					nextOp.regM = fields.rmIsR1 ? `DECOP_GR_GBR : `DECOP_GR_PC;
					nextOp.uIxt = memIxtBase;
				end
			end
			FM_LDDRREGREG, FM_REGSTDRREG: begin
				nextOp.regN = fields.regN;
				nextOp.regM = fields.regM;
				nextOp.regO = fields.regO;
				nextOp.uIxt = memIxt;
				if (fields.rmIsRz) begin
					nextOp.uIxt = memIxtBase;
					// R1 index with R0/R1 base selects DLR or TBR
					case ({fields.rmIsR1, fields.roIsR1})
						2'b11: begin
							nextOp.regM = `DECOP_GR_TBR;
							nextOp.regO = `DECOP_GR_DLR;
						end
						2'b10: nextOp.regM = `DECOP_GR_GBR;
						2'b01: begin
							nextOp.regM = `DECOP_GR_DLR;
							nextOp.regO = `DECOP_GR_ZZR;
						end
						default: nextOp.regM = `DECOP_GR_PC;
					endcase
				end
			end
			FM_IMM8REG: begin
				nextOp.regM = `DECOP_GR_IMM;
				nextOp.regN = fields.regO2;
				nextOp.regO = fields.regO2;
				nextOp.uIxt = aluIxt;
				case (opClass.ity)
					ITY_SW: nextOp.imm = imms.imm16s;
					ITY_UW: nextOp.imm = imms.imm16u;
					ITY_NW: nextOp.imm = imms.imm16n;
					default: begin
						nextOp.regN = fields.regN;
						nextOp.regO = fields.regN;
						if (opClass.ity == ITY_NQ)
							nextOp.imm = imms.imm10n;
						else if (opClass.ity == ITY_UQ)
							nextOp.imm = imms.imm10u;
						else
							nextOp.imm = imms.imm10s;
					end
				endcase
			end
			FM_PCDISP8: begin
				nextOp.regN = `DECOP_GR_DLR;
				nextOp.regM = `DECOP_GR_PC;
				nextOp.regO = `DECOP_GR_IMM;
				nextOp.imm = imms.disp20s;
				nextOp.uIxt = memIxt;
			end
			FM_IMM12Z, FM_IMM12N: begin
				nextOp.regN = `DECOP_GR_DLR;
				nextOp.regM = `DECOP_GR_IMM;
				nextOp.imm = (opClass.fmid == FM_IMM12N) ? imms.imm12n : imms.imm12z;
				nextOp.uIxt = aluIxt;
			end
			default: begin
				// Z and INV
				nextOp.uCmd = {opClass.ccty, `DECOP_UCMD_INVOP};
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			decodedOp.regN <= `DECOP_GR_ZZR;
			decodedOp.regM <= `DECOP_GR_ZZR;
			decodedOp.regO <= `DECOP_GR_ZZR;
			decodedOp.imm <= '0;
			decodedOp.uCmd <= {CC_AL, `DECOP_UCMD_INVOP};
			decodedOp.uIxt <= '0;
		end else begin
			decodedOp <= nextOp;
		end
	end

	// a non-F word leaves no operands behind
	assert property (@(posedge clock) disable iff (reset)
		(istrWord[15:13] != 3'b111) |=>
		(decodedOp.regN == `DECOP_GR_ZZR && decodedOp.regM == `DECOP_GR_ZZR &&
		decodedOp.regO == `DECOP_GR_ZZR));

	assert property (@(posedge clock) disable iff (reset)
		opClass.fmid inside {FM_Z, FM_INV, FM_REGREG, FM_REGIMMREG, FM_LDREGDISPREG,
		FM_REGSTREGDISP, FM_LDDRREGREG, FM_REGSTDRREG, FM_IMM8REG, FM_PCDISP8,
		FM_IMM12Z, FM_IMM12N});

endmodule

// ==== verilog/decOpFz.sv ====
// one-cycle decode of a 32-bit F-block word, a new word accepted every cycle
`timescale 1ns/1ps

module decOpFz (
	input logic clock,
	input logic reset,
	input decOpPkg::istrWord_t istrWord,
	output decOpPkg::decodedOp_t decodedOp
);
	import decOpPkg::*;

	istrFields_t fields;
	immSet_t imms;
	opClass_t opClass;

	opFieldSplit u_fields (
		.istrWord(istrWord),
		.fields(fields)
	);

	immExtend u_imm (
		.istrWord(istrWord),
		.imms(imms)
	);

	opClassDecode u_class (
		.istrWord(istrWord),
		.opClass(opClass)
	);

	// only registered stage
	operandForm u_form (
		.clock(clock),
		.reset(reset),
		.istrWord(istrWord),
		.fields(fields),
		.imms(imms),
		.opClass(opClass),
		.decodedOp(decodedOp)
	);

endmodule

// ==== verif/decOpVectors.svh ====
// hand-worked vectors, rows apply back to back so each check sees the previous row's word
`ifndef DECOP_VECTORS_SVH
`define DECOP_VECTORS_SVH

string rowName[$];
istrWord_t rowWord[$];
decodedOp_t rowExp[$];

task automatic addRow(input string name, input istrWord_t word,
		input regId_t expN, input regId_t expM, input regId_t expO,
		input imm_t expImm, input uCmd_t expCmd, input uIxt_t expIxt);
	decodedOp_t op;
	op.regN = expN;
	op.regM = expM;
	op.regO = expO;
	op.imm = expImm;
	op.uCmd = expCmd;
	op.uIxt = expIxt;
	rowName.push_back(name);
	rowWord.push_back(word);
	rowExp.push_back(op);
endtask

// words that must come out as INVOP with no operands
task automatic addInvalid(input string name, input istrWord_t word);
	addRow(name, word, `DECOP_GR_ZZR, `DECOP_GR_ZZR, `DECOP_GR_ZZR,
		33'h0, {2'b00, `DECOP_UCMD_INVOP}, 8'h00);
endtask

task automatic buildTable();
	// F0 register-register, imm carries bits 4:0
	addRow("ADD SB", 32'h1030F045, 6'h04, 6'h05, 6'h03,
		33'h5, {2'b00, `DECOP_UCMD_ALU3}, 8'h00);
	addRow("SUB SB special", 32'h10F1F001, 6'h20, 6'h21, 6'h2F,
		33'h1, {2'b00, `DECOP_UCMD_ALU3}, 8'h01);
	addRow("XOR SB ext", 32'h1627F0EF, 6'h1E, 6'h3F, 6'h02,
		33'hF, {2'b00, `DECOP_UCMD_ALU3}, 8'h07);
	addRow("AND UB", 32'h1058F023, 6'h02, 6'h03, 6'h02,
		33'h3, {2'b00, `DECOP_UCMD_ALU3}, 8'h05);
	addRow("OR NB", 32'h1069F0A7, 6'h0A, 6'h0A, 6'h07,
		33'h7, {2'b00, `DECOP_UCMD_ALU3}, 8'h06);
	addInvalid("non-F word", 32'h1030A045);

	// indexed loads, stores and LEA
	addRow("MOV.L store", 32'h0036F045, 6'h04, 6'h05, 6'h03,
		33'h0, {2'b00, `DECOP_UCMD_MOV_RM}, 8'h2A);
	addRow("MOV.W load R0", 32'h003DF040, 6'h04, `DECOP_GR_PC, 6'h03,
		33'h0, {2'b00, `DECOP_UCMD_MOV_MR}, 8'h18);
	addRow("MOVU.B load R1", 32'h083CF041, 6'h04, `DECOP_GR_GBR, 6'h03,
		33'h0, {2'b00, `DECOP_UCMD_MOV_MR}, 8'h0C);
	addRow("MOV.W load R1 R1", 32'h001DF041, 6'h04, `DECOP_GR_TBR, `DECOP_GR_DLR,
		33'h0, {2'b00, `DECOP_UCMD_MOV_MR}, 8'h18);
	addRow("LEA.W indexed", 32'h0835F045, 6'h04, 6'h05, 6'h03,
		33'h0, {2'b00, `DECOP_UCMD_LEA_MR}, 8'h19);

	// F1 displacement forms, imm17 zero extended
	addRow("MOV.L disp store", 32'h2010F145, 6'h04, 6'h05, `DECOP_GR_IMM,
		33'h10, {2'b00, `DECOP_UCMD_MOV_RM}, 8'h2A);
	addRow("MOV.W disp R0", 32'h9134F160, 6'h06, `DECOP_GR_PC, `DECOP_GR_IMM,
		33'h134, {2'b00, `DECOP_UCMD_MOV_MR}, 8'h18);
	addRow("MOVU.L disp R1", 32'hA808F171, 6'h07, `DECOP_GR_GBR, `DECOP_GR_IMM,
		33'h8, {2'b00, `DECOP_UCMD_MOV_MR}, 8'h2C);
	addRow("LEA.B disp", 32'h0820F145, 6'h04, 6'h05, `DECOP_GR_IMM,
		33'h20, {2'b00, `DECOP_UCMD_LEA_MR}, 8'h08);
	addInvalid("undefined F0", 32'h2000F045);

	// F2 register-immediate
	addRow("ADD imm17u", 32'h0045F245, 6'h04, 6'h05, `DECOP_GR_IMM,
		33'h45, {2'b00, `DECOP_UCMD_ALU3}, 8'h00);
	addRow("ADD imm17n", 32'h1003F245, 6'h04, 6'h05, `DECOP_GR_IMM,
		33'h1FFFFFE03, {2'b00, `DECOP_UCMD_ALU3}, 8'h00);
	addRow("AND imm17u", 32'h500FF2A7, 6'h0A, 6'h07, `DECOP_GR_IMM,
		33'hF, {2'b00, `DECOP_UCMD_ALU3}, 8'h05);
	addRow("OR imm17u bit8", 32'h6180F245, 6'h04, 6'h05, `DECOP_GR_IMM,
		33'h180, {2'b00, `DECOP_UCMD_ALU3}, 8'h06);
	addRow("MOV imm10u", 32'hC025F240, 6'h04, `DECOP_GR_IMM, 6'h04,
		33'h25, {2'b00, `DECOP_UCMD_MOV_IR}, 8'h00);
	addRow("MOV imm10n", 32'hC025F241, 6'h04, `DECOP_GR_IMM, 6'h04,
		33'h1FFFFFC25, {2'b00, `DECOP_UCMD_MOV_IR}, 8'h00);
	addRow("CMPEQ imm10u", 32'hC207F24C, 6'h04, `DECOP_GR_IMM, 6'h04,
		33'h207, {2'b00, `DECOP_UCMD_ALUCMP}, 8'h18);
	addRow("CMPQGT imm10u", 32'hC810F24E, 6'h04, `DECOP_GR_IMM, 6'h04,
		33'h10, {2'b00, `DECOP_UCMD_ALUCMP}, 8'h1B);
	addInvalid("undefined F2", 32'hC000F242);

	// F8 takes its register from bits 4:0
	addRow("LDIZ imm16u", 32'h1234F805, 6'h05, `DECOP_GR_IMM, 6'h05,
		33'h1234, {2'b00, `DECOP_UCMD_MOV_IR}, 8'h00);
	addRow("LDIN imm16n", 32'h8000F83A, 6'h1A, `DECOP_GR_IMM, 6'h1A,
		33'h1FFFF8000, {2'b00, `DECOP_UCMD_MOV_IR}, 8'h00);
	addRow("ADD imm16s", 32'hFFF0F841, 6'h21, `DECOP_GR_IMM, 6'h21,
		33'h1FFFFFFF0, {2'b00, `DECOP_UCMD_ALU3}, 8'h00);
	addRow("LDISH16", 32'hABCDF962, 6'h02, `DECOP_GR_IMM, 6'h02,
		33'hABCD, {2'b00, `DECOP_UCMD_MOV_IR}, 8'h01);
	addInvalid("undefined F8", 32'h0000F880);

	// FA and FB, 24-bit immediate into DLR
	addRow("FA imm24 zero", 32'h3456FA12, `DECOP_GR_DLR, `DECOP_GR_IMM, `DECOP_GR_ZZR,
		33'h123456, {2'b00, `DECOP_UCMD_MOV_IR}, 8'h00);
	addRow("FB imm24 ones", 32'h0001FB80, `DECOP_GR_DLR, `DECOP_GR_IMM, `DECOP_GR_ZZR,
		33'h1FF800001, {2'b00, `DECOP_UCMD_MOV_IR}, 8'h00);

	// branches, disp20 sign extended
	addRow("BRA", 32'hC123F000, `DECOP_GR_DLR, `DECOP_GR_PC, `DECOP_GR_IMM,
		33'h123, {2'b00, `DECOP_UCMD_BRA}, 8'h19);
	addRow("BSR", 32'hD800F0FF, `DECOP_GR_DLR, `DECOP_GR_PC, `DECOP_GR_IMM,
		33'h1FFFFF800, {2'b00, `DECOP_UCMD_BSR}, 8'h19);
	addRow("BT", 32'hE010F001, `DECOP_GR_DLR, `DECOP_GR_PC, `DECOP_GR_IMM,
		33'h1010, {2'b10, `DECOP_UCMD_BRA}, 8'h99);
	addRow("BF", 32'hF004F080, `DECOP_GR_DLR, `DECOP_GR_PC, `DECOP_GR_IMM,
		33'h1FFF80004, {2'b11, `DECOP_UCMD_BRA}, 8'hD9);
	addInvalid("all ones", 32'hFFFFFFFF);
	addRow("ADD SB again", 32'h1030F045, 6'h04, 6'h05, 6'h03,
		33'h5, {2'b00, `DECOP_UCMD_ALU3}, 8'h00);
endtask

`endif

// ==== verif/decOpTb.sv ====
// one word per cycle from the table, result checked one cycle later; stops at the first error
`timescale 1ns/1ps
`include "decOp_params.svh"

module decOpTb;
	import decOpPkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int EDGE_TIMEOUT = 40;

	logic clock;
	logic reset;
	istrWord_t istrWord;
	decodedOp_t decodedOp;
	decodedOp_t resetOp;
	int edgeCount;
	int rowIx;

	`include "decOpVectors.svh"

	decOpFz dut0 (
		.clock(clock),
		.reset(reset),
		.istrWord(istrWord),
		.decodedOp(decodedOp)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		edgeCount = edgeCount + 1;
	end

	task automatic checkValue(input string testName, input string field,
			input logic [39:0] expected, input logic [39:0] actual);
		if (actual !== expected) begin
			$display("Mismatch in %s, %s: expected %h, actual %h",
				testName, field, expected, actual);
			$display("** FAIL **");
			$fatal(1, "decoded value differs from the table");
		end
	endtask

	task automatic compareOp(input string testName, input decodedOp_t expected,
			input decodedOp_t actual);
		checkValue(testName, "regN", 40'(expected.regN), 40'(actual.regN));
		checkValue(testName, "regM", 40'(expected.regM), 40'(actual.regM));
		checkValue(testName, "regO", 40'(expected.regO), 40'(actual.regO));
		checkValue(testName, "imm", 40'(expected.imm), 40'(actual.imm));
		checkValue(testName, "uCmd", 40'(expected.uCmd), 40'(actual.uCmd));
		checkValue(testName, "uIxt", 40'(expected.uIxt), 40'(actual.uIxt));
	endtask

	// lands 1 ns after the next rising edge, polling off the edge times
	task automatic stepCycle();
		int startCount;
		int polls;
		startCount = edgeCount;
		polls = 0;
		#0.5;
		while (edgeCount == startCount && polls < EDGE_TIMEOUT) begin
			#1;
			polls++;
		end
		if (edgeCount == startCount) begin
			$display("no rising clock edge within %0d ns", EDGE_TIMEOUT);
			$display("** FAIL **");
			$fatal(1, "clock stopped");
		end
		#0.5;
	endtask

	initial begin
		buildTable();
		clock = 1'b0;
		reset = 1'b1;
		edgeCount = 0;
		istrWord = rowWord[0];
		resetOp.regN = `DECOP_GR_ZZR;
		resetOp.regM = `DECOP_GR_ZZR;
		resetOp.regO = `DECOP_GR_ZZR;
		resetOp.imm = '0;
		resetOp.uCmd = {2'b00, `DECOP_UCMD_INVOP};
		resetOp.uIxt = '0;

		// reset must win over whatever word is present
		for (int i = 0; i < RESET_CYCLES; i++) begin
			stepCycle();
			compareOp("reset", resetOp, decodedOp);
			istrWord = rowWord[(i + 1) % rowWord.size()];
		end

		reset = 1'b0;
		istrWord = rowWord[0];
		for (rowIx = 1; rowIx <= rowWord.size(); rowIx++) begin
			stepCycle();
			compareOp(rowName[rowIx - 1], rowExp[rowIx - 1], decodedOp);
			if (rowIx < rowWord.size())
				istrWord = rowWord[rowIx];
		end

		$display("checked %0d table rows", rowWord.size());
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+verilog
+incdir+verif
verilog/decOpPkg.sv
verilog/opFieldSplit.sv
verilog/immExtend.sv
verilog/opClassDecode.sv
verilog/operandForm.sv
verilog/decOpFz.sv
verif/decOpTb.sv

// ==== Bender.yml ====
package:
  name: dec_op_fz

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/decOpPkg.sv
      - verilog/opFieldSplit.sv
      - verilog/immExtend.sv
      - verilog/opClassDecode.sv
      - verilog/operandForm.sv
      - verilog/decOpFz.sv
  - target: test
    include_dirs:
      - verilog
      - verif
    files:
      - verif/decOpTb.sv
